// ==== build.f ====
+incdir+design
design/spi_pkg.sv
design/adc_pkg.sv
design/adc_init_rom.sv
design/adc_init_seq.sv
design/spi_master.sv
design/adc_init_top.sv
tb/adc_init_tb.sv

// ==== tb/adc_init_tb.sv ====
`default_nettype none

`include "adc_init_cfg.svh"

module adc_init_tb
    import spi_pkg::*;
    import adc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS      = 4;
    localparam int FRAME_CLKS  = 32 * `ADC_SCK_DIV + `ADC_CS_GAP + 4;
    localparam int WATCHDOG_NS = 2 * 3 * `ADC_INIT_LEN * FRAME_CLKS * CLK_NS;
    localparam int IDLE_CLKS   = 2 * FRAME_CLKS; // Long enough for a stray frame to finish.

    // Register addresses in table order, entry 0 in the low byte.
    localparam logic [18*8-1:0] REF_ADDRS =
    {
        8'h20, 8'h1F, 8'h18, 8'h17, 8'h16, 8'h15, 8'h14, 8'h13, 8'h12,
        8'h11, 8'h10, 8'h0F, 8'h0D, 8'h0C, 8'h0B, 8'h08, 8'h07, 8'h06
    };

    logic O_tx_done;
    logic I_rst_n;
    logic tx_en;
    logic spi_sck;
    logic spi_mosi;
    logic spi_cs_n;
    logic cfg_busy;
    logic cfg_done;

    spi_word_t  frames[$];     // Words seen by the slave model.
    spi_word_t  shift_word;
    seq_index_t rise_cnt;
    logic       prev_cs;
    logic       prev_sck;
    logic       prev_done;
    logic       in_run;
    integer     seed;

    adc_init_top dut
    (
        .O_tx_done (O_tx_done),
        .I_rst_n   (I_rst_n),
        .tx_en     (tx_en),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_cs_n  (spi_cs_n),
        .cfg_busy  (cfg_busy),
        .cfg_done  (cfg_done)
    );

    always #2 O_tx_done = ~O_tx_done;

    // ######################################################################
    // Expected values and compare tasks
    // ######################################################################

    function automatic spi_word_t ref_entry(input seq_index_t k);
        adc_reg_addr_t addr;
        adc_reg_data_t data;
        addr = REF_ADDRS[k*8 +: 8];
        if (addr == 8'h06)
            data = 8'h02;
        else if (addr == 8'h07)
            data = 8'h55;
        else
            data = 8'h07; // Common setting.
        return {addr, data};
    endfunction

    task automatic check_word(input string name, input spi_word_t exp, input spi_word_t act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic check_count(input string name, input seq_index_t exp, input seq_index_t act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // ######################################################################
    // SPI slave model and protocol monitor
    // ######################################################################

    always @(posedge O_tx_done)
    begin
        if (!I_rst_n)
        begin
            prev_cs    = 1'b1;
            prev_sck   = 1'b0;
            prev_done  = 1'b0;
            rise_cnt   = '0;
            shift_word = '0;
            in_run     = 1'b0; // Partial frame is dropped.
        end
        else
        begin
            if (prev_cs && !spi_cs_n)
            begin
                check_flag("sck at cs fall", 1'b0, spi_sck);
                check_flag("busy at frame start", 1'b1, cfg_busy);
                rise_cnt   = '0;
                shift_word = '0;
                in_run     = 1'b1;
            end
            if (!spi_cs_n && spi_sck && !prev_sck)
            begin
                shift_word = {shift_word[14:0], spi_mosi}; // MSB first.
                rise_cnt   = rise_cnt + 1'b1;
            end
            if (!prev_cs && spi_cs_n)
            begin
                check_flag("sck at cs rise", 1'b0, spi_sck);
                check_count("sck rises per frame", 5'd16, rise_cnt);
                check_flag("done at cs rise", 1'b0, cfg_done);
                frames.push_back(shift_word);
            end
            if (in_run)
            begin
                if (cfg_done)
                begin
                    check_flag("busy with done", 1'b0, cfg_busy);
                    in_run = 1'b0;
                end
                else
                    check_flag("busy during run", 1'b1, cfg_busy);
            end
            if (cfg_done && !prev_done)
                check_count("frames before done", 5'(`ADC_INIT_LEN), 5'(frames.size()));
            prev_cs   = spi_cs_n;
            prev_sck  = spi_sck;
            prev_done = cfg_done;
        end
    end

    // ######################################################################
    // Stimulus
    // ######################################################################

    task automatic pulse_start();
        @(posedge O_tx_done);
        tx_en <= 1'b1;
        @(posedge O_tx_done);
        tx_en <= 1'b0;
    endtask

    task automatic wait_done();
        do
            @(posedge O_tx_done);
        while (!cfg_done);
    endtask

    task automatic run_table(input string name);
        int k;
        frames.delete();
        pulse_start();
        wait_done();
        check_count({name, " frame count"}, 5'(`ADC_INIT_LEN), 5'(frames.size()));
        for (k = 0; k < `ADC_INIT_LEN; k++)
            check_word($sformatf("%s frame %0d", name, k), ref_entry(5'(k)), frames[k]);
        // No traffic while start stays low.
        repeat (IDLE_CLKS) @(posedge O_tx_done);
        check_count({name, " frames while idle"}, 5'(`ADC_INIT_LEN), 5'(frames.size()));
        check_flag({name, " done held"}, 1'b1, cfg_done);
        check_flag({name, " cs idle"}, 1'b1, spi_cs_n);
    endtask

    task automatic random_gap();
        int gap;
        gap = ($random(seed) & 63) + 4;
        repeat (gap) @(posedge O_tx_done);
    endtask

    initial
    begin
        seed      = 32'hc53f_4250;
        O_tx_done = 1'b0;
        I_rst_n   = 1'b0;
        tx_en     = 1'b0;

        repeat (5) @(posedge O_tx_done);
        I_rst_n <= 1'b1;
        repeat (3) @(posedge O_tx_done);
        check_flag("reset cs_n", 1'b1, spi_cs_n);
        check_flag("reset sck", 1'b0, spi_sck);
        check_flag("reset mosi", 1'b0, spi_mosi);
        check_flag("reset busy", 1'b0, cfg_busy);
        check_flag("reset done", 1'b0, cfg_done);

        random_gap();
        run_table("run 1");

        random_gap();
        run_table("run 2");

        // Reset in the middle of the third frame.
        random_gap();
        frames.delete();
        pulse_start();
        while (frames.size() < 2)
            @(posedge O_tx_done);
        while (spi_cs_n)
            @(posedge O_tx_done);
        repeat (40) @(posedge O_tx_done);
        I_rst_n <= 1'b0;
        repeat (5) @(posedge O_tx_done);
        check_flag("mid-frame reset cs_n", 1'b1, spi_cs_n);
        check_flag("mid-frame reset sck", 1'b0, spi_sck);
        check_flag("mid-frame reset busy", 1'b0, cfg_busy);
        I_rst_n <= 1'b1;

        random_gap();
        run_table("run after reset");

        $display("Simulation completed successfully");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// ==== design/adc_init_top.sv ====
`default_nettype none

module adc_init_top
    import spi_pkg::*;
    import adc_pkg::*;
(
    input  logic O_tx_done,
    input  logic I_rst_n,
    input  logic tx_en,
    output logic spi_sck,
    output logic spi_mosi,
    output logic spi_cs_n,
    output logic cfg_busy,
    output logic cfg_done
);

    seq_index_t    index;
    adc_reg_addr_t reg_addr;
    adc_reg_data_t reg_data;
    spi_word_t     frame_word;
    logic          frame_start;
    logic          frame_done;

    adc_init_seq u_seq
    (
        .O_tx_done   (O_tx_done),
        .I_rst_n     (I_rst_n),
        .tx_en       (tx_en),
        .frame_done  (frame_done),
        .reg_addr    (reg_addr),
        .reg_data    (reg_data),
        .index       (index),
        .frame_word  (frame_word),
        .frame_start (frame_start),
        .cfg_busy    (cfg_busy),
        .cfg_done    (cfg_done)
    );

    // Register table lookup.
    adc_init_rom u_rom
    (
        .index    (index),
        .reg_addr (reg_addr),
        .reg_data (reg_data)
    );

    spi_master u_spi
    (
        .O_tx_done   (O_tx_done),
        .I_rst_n     (I_rst_n),
        .frame_start (frame_start),
        .frame_word  (frame_word),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_cs_n    (spi_cs_n),
        .frame_done  (frame_done)
    );

endmodule

`default_nettype wire

// ==== design/spi_master.sv ====
`default_nettype none

`include "adc_init_cfg.svh"

module spi_master
    import spi_pkg::*;
(
    input  logic      O_tx_done,
    input  logic      I_rst_n,
    input  logic      frame_start,
    input  spi_word_t frame_word,
    output logic      spi_sck,
    output logic      spi_mosi,
    output logic      spi_cs_n,
    output logic      frame_done
);

    spi_state_t   state;
    logic [7:0]   tick_cnt;  // SCK divider, reused for the gap.
    spi_bit_cnt_t bit_cnt;
    spi_word_t    shreg;
    logic         sck_tick;
    logic         gap_end;
    logic         sck_fall;
    logic         launch;

    assign sck_tick = (tick_cnt == 8'(`ADC_SCK_DIV - 1));
    assign gap_end  = (tick_cnt == 8'(`ADC_CS_GAP - 1));
    assign sck_fall = (state == SPI_SHIFT) && sck_tick && spi_sck;
    assign launch   = (state == SPI_IDLE) && frame_start;

    // ######################################################################
    // Frame timing
    // ######################################################################

    always_ff @(posedge O_tx_done or negedge I_rst_n)
    begin
        if (!I_rst_n)
        begin
            state      <= SPI_IDLE;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            spi_sck    <= 1'b0;
            spi_mosi   <= 1'b0;
            spi_cs_n   <= 1'b1;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            case (state)
                SPI_IDLE:
                begin
                    if (frame_start)
                    begin
                        spi_cs_n <= 1'b0;
                        spi_mosi <= frame_word[15]; // MSB set up before first rise.
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= SPI_SHIFT;
                    end
                end
                SPI_SHIFT:
                begin
                    if (sck_tick)
                    begin
                        tick_cnt <= '0;
                        if (!spi_sck)
                            spi_sck <= 1'b1; // Slave samples here.
                        else
                        begin
                            spi_sck  <= 1'b0;
                            spi_mosi <= shreg[15];
                            if (bit_cnt == spi_bit_cnt_t'(15))
                            begin
                                // Last fall, CS rises on the same edge.
                                spi_cs_n <= 1'b1;
                                state    <= SPI_GAP;
                            end
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    else
                        tick_cnt <= tick_cnt + 1'b1;
                end
                SPI_GAP:
                begin
                    if (gap_end)
                    begin
                        tick_cnt   <= '0;
                        frame_done <= 1'b1;
                        state      <= SPI_IDLE;
                    end
                    else
                        tick_cnt <= tick_cnt + 1'b1;
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    // Zeros shift in, so MOSI is back low after the last bit.
    always_ff @(posedge O_tx_done)
    begin
        if (launch)
            shreg <= {frame_word[14:0], 1'b0};
        else if (sck_fall)
            shreg <= {shreg[14:0], 1'b0};
    end

    // ######################################################################
    // Checks
    // ######################################################################

    a_sck_idle_low: assert property (@(posedge O_tx_done) disable iff (!I_rst_n)
        spi_cs_n |-> !spi_sck);

    a_done_pulse: assert property (@(posedge O_tx_done) disable iff (!I_rst_n)
        frame_done |=> !frame_done);

endmodule

`default_nettype wire

// ==== design/adc_init_seq.sv ====
`default_nettype none

`include "adc_init_cfg.svh"

module adc_init_seq
    import spi_pkg::*;
    import adc_pkg::*;
(
    input  logic          O_tx_done,
    input  logic          I_rst_n,
    input  logic          tx_en,
    input  logic          frame_done,
    input  adc_reg_addr_t reg_addr,
    input  adc_reg_data_t reg_data,
    output seq_index_t    index,
    output spi_word_t     frame_word,
    output logic          frame_start,
    output logic          cfg_busy,
    output logic          cfg_done
);

    seq_state_t state;
    logic       tx_en_d;
    logic       start;
    logic       last_entry;
    logic       load;

    assign start = tx_en && !tx_en_d;

    // Issued for the single cycle spent in LAUNCH.
    assign frame_start = (state == SEQ_LAUNCH);

    // Index is 0 in idle and done, so entry 0 is ready at start.
    assign load = (start && (state == SEQ_IDLE || state == SEQ_DONE)) ||
                  (state == SEQ_WAIT && frame_done && !last_entry);

    // ######################################################################
    // Run control
    // ######################################################################

    always_ff @(posedge O_tx_done or negedge I_rst_n)
    begin
        if (!I_rst_n)
        begin
            state      <= SEQ_IDLE;
            tx_en_d    <= 1'b0;
            index      <= '0;
            last_entry <= 1'b0;
            cfg_busy   <= 1'b0;
            cfg_done   <= 1'b0;
        end
        else
        begin
            tx_en_d <= tx_en;
            case (state)
                SEQ_IDLE, SEQ_DONE:
                begin
                    if (start)
                    begin
                        cfg_busy <= 1'b1;
                        cfg_done <= 1'b0;
                        state    <= SEQ_LAUNCH;
                    end
                end
                SEQ_LAUNCH:
                begin
                    // Step ahead so the next pair is ready when the frame ends.
                    last_entry <= (index == seq_index_t'(`ADC_INIT_LEN - 1));
                    if (index != seq_index_t'(`ADC_INIT_LEN - 1))
                        index <= index + 1'b1;
                    state <= SEQ_WAIT;
                end
                SEQ_WAIT:
                begin
                    if (frame_done)
                    begin
                        if (last_entry)
                        begin
                            cfg_busy <= 1'b0;
                            cfg_done <= 1'b1;
                            index    <= '0;
                            state    <= SEQ_DONE;
                        end
                        else
                            state <= SEQ_LAUNCH;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge O_tx_done)
    begin
        if (load)
            frame_word <= {reg_addr, reg_data}; // Address goes out first.
    end

    // ######################################################################
    // Checks
    // ######################################################################

    a_start_then_wait: assert property (@(posedge O_tx_done) disable iff (!I_rst_n)
        frame_start |=> (state == SEQ_WAIT) && !frame_start);

    a_index_range: assert property (@(posedge O_tx_done) disable iff (!I_rst_n)
        index < seq_index_t'(`ADC_INIT_LEN));

endmodule

`default_nettype wire

// ==== design/adc_init_rom.sv ====
`default_nettype none

`include "adc_init_cfg.svh"

module adc_init_rom
    import adc_pkg::*;
(
    input  seq_index_t    index,
    output adc_reg_addr_t reg_addr,
    output adc_reg_data_t reg_data
);

    always_comb
    begin
        reg_addr = '0;
        reg_data = '0;
        if (index < seq_index_t'(`ADC_INIT_LEN))
        begin
            reg_data = 8'h07; // Most registers take the same value.
            case (index)
                5'd0:
                begin
                    reg_addr = 8'h06;
                    reg_data = 8'h02;
                end
                5'd1:
                begin
                    reg_addr = 8'h07;
                    reg_data = 8'h55; // Alternating pattern.
                end
                5'd2:    reg_addr = 8'h08;
                5'd3:    reg_addr = 8'h0B;
                5'd4:    reg_addr = 8'h0C;
                5'd5:    reg_addr = 8'h0D;
                5'd6:    reg_addr = 8'h0F;
                5'd7:    reg_addr = 8'h10;
                5'd8:    reg_addr = 8'h11;
                5'd9:    reg_addr = 8'h12;
                5'd10:   reg_addr = 8'h13;
                5'd11:   reg_addr = 8'h14;
                5'd12:   reg_addr = 8'h15;
                5'd13:   reg_addr = 8'h16;
                5'd14:   reg_addr = 8'h17;
                5'd15:   reg_addr = 8'h18;
                5'd16:   reg_addr = 8'h1F;
                5'd17:   reg_addr = 8'h20; // Last entry.
                default:
                begin
                    reg_addr = '0;
                    reg_data = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/adc_pkg.sv ====
`default_nettype none

package adc_pkg;

    // ADC register map fields.
    typedef logic [7:0] adc_reg_addr_t;
    typedef logic [7:0] adc_reg_data_t;

    // Position in the init table.
    typedef logic [4:0] seq_index_t;

    typedef enum logic [1:0]
    {
        SEQ_IDLE   = 2'd0, // No run since reset.
        SEQ_LAUNCH = 2'd1, // Frame start is issued here.
        SEQ_WAIT   = 2'd2, // Frame on the wire.
        SEQ_DONE   = 2'd3  // Table sent, done level held.
    } seq_state_t;

endpackage

`default_nettype wire

// ==== design/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

    // One frame on the wire, address in the upper byte.
    typedef logic [15:0] spi_word_t;

    // Bit position inside a frame.
    typedef logic [4:0] spi_bit_cnt_t;

    typedef enum logic [1:0]
    {
        SPI_IDLE  = 2'd0, // Chip select high, waiting for a start.
        SPI_SHIFT = 2'd1,
        SPI_GAP   = 2'd2  // Chip select high, minimum gap.
    } spi_state_t;

endpackage

`default_nettype wire

// ==== design/adc_init_cfg.svh ====
`ifndef ADC_INIT_CFG_SVH
`define ADC_INIT_CFG_SVH

// ######################################################################
// SPI timing
// ######################################################################

// System clocks per SCK half period.
`define ADC_SCK_DIV 4

// Clocks with chip select high between two frames.
`define ADC_CS_GAP 8

// ######################################################################
// Register table
// ######################################################################

`define ADC_INIT_LEN 18 // Address/value pairs sent per run.

`endif
